// ==== source/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

	typedef enum logic [2:0] {
		REG_NONE,
		REG_ROM,
		REG_VRAM,
		REG_XRAM,
		REG_WRAM,
		REG_OAM,
		REG_IO,
		REG_HRAM
	} region_t;

	typedef logic [15:0] addr_t;
	typedef logic [7:0] data_t;

	localparam addr_t ROM_BASE = 16'h0000;
	localparam addr_t ROM_LIMIT = 16'h7fff;
	localparam addr_t VRAM_BASE = 16'h8000;
	localparam addr_t VRAM_LIMIT = 16'h9fff;
	localparam addr_t XRAM_BASE = 16'ha000;
	localparam addr_t XRAM_LIMIT = 16'hbfff;
	localparam addr_t WRAM_BASE = 16'hc000;
	localparam addr_t WRAM_LIMIT = 16'hdfff;
	localparam addr_t ECHO_BASE = 16'he000;   // Mirrors work RAM
	localparam addr_t ECHO_LIMIT = 16'hfdff;
	localparam addr_t OAM_BASE = 16'hfe00;
	localparam addr_t OAM_LIMIT = 16'hfe9f;
	localparam addr_t IO_BASE = 16'hff00;
	localparam addr_t IO_LIMIT = 16'hff7f;
	localparam addr_t HRAM_BASE = 16'hff80;
	localparam addr_t HRAM_LIMIT = 16'hfffe;
	localparam addr_t IE_ADDR = 16'hffff;     // Interrupt enable sits above HRAM

	localparam int VRAM_WORDS = 8192;
	localparam int OAM_BYTES = 160;
	localparam int HRAM_BYTES = 127;

	localparam addr_t DMA_REG_ADDR = 16'hff46;
	localparam data_t OPEN_BUS = 8'hff;

	localparam int NUM_MASTERS = 3;
	localparam int M_CPU = 0;
	localparam int M_DMA = 1;
	localparam int M_PPU = 2;

endpackage

`default_nettype wire

// ==== source/bus_req_if.sv ====
`default_nettype none

interface bus_req_if;

	mem_bus_pkg::addr_t addr;
	logic rd;
	logic wr;
	mem_bus_pkg::data_t wdata;
	mem_bus_pkg::region_t region;

	modport master (
		output addr, rd, wr, wdata
	);

	modport decoder (
		input addr, rd, wr,
		output region
	);

	modport steer (
		input addr, rd, wr, wdata, region
	);

endinterface

`default_nettype wire

// ==== source/region_decoder.sv ====
`default_nettype none

module region_decoder (
	bus_req_if.decoder req
);

	mem_bus_pkg::addr_t a;
	logic in_wram;
	logic in_io;

	assign a = req.addr;

	assign in_wram = (a >= mem_bus_pkg::WRAM_BASE && a <= mem_bus_pkg::WRAM_LIMIT) ||
		(a >= mem_bus_pkg::ECHO_BASE && a <= mem_bus_pkg::ECHO_LIMIT);

	assign in_io = (a >= mem_bus_pkg::IO_BASE && a <= mem_bus_pkg::IO_LIMIT) ||
		a == mem_bus_pkg::IE_ADDR;

	always_comb begin
		req.region = mem_bus_pkg::REG_NONE;   // Idle cycles decode as nothing

		if (req.rd || req.wr) begin
			if (a >= mem_bus_pkg::ROM_BASE && a <= mem_bus_pkg::ROM_LIMIT) begin
				req.region = mem_bus_pkg::REG_ROM;
			end else if (a >= mem_bus_pkg::VRAM_BASE && a <= mem_bus_pkg::VRAM_LIMIT) begin
				req.region = mem_bus_pkg::REG_VRAM;
			end else if (a >= mem_bus_pkg::XRAM_BASE && a <= mem_bus_pkg::XRAM_LIMIT) begin
				req.region = mem_bus_pkg::REG_XRAM;
			end else if (in_wram) begin
				req.region = mem_bus_pkg::REG_WRAM;
			end else if (a >= mem_bus_pkg::OAM_BASE && a <= mem_bus_pkg::OAM_LIMIT) begin
				req.region = mem_bus_pkg::REG_OAM;
			end else if (in_io) begin
				req.region = mem_bus_pkg::REG_IO;
			end else if (a >= mem_bus_pkg::HRAM_BASE && a <= mem_bus_pkg::HRAM_LIMIT) begin
				req.region = mem_bus_pkg::REG_HRAM;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/oam_dma.sv ====
`default_nettype none

module oam_dma (
	input logic gbclk,
	input logic arst_n,
	bus_req_if.steer cpu,
	bus_req_if.master dma,
	output logic [7:0] oam_index,
	output logic dma_active
);

	logic [7:0] page;
	logic [7:0] cnt;
	logic start;
	logic last;

	assign start = cpu.wr && cpu.addr == mem_bus_pkg::DMA_REG_ADDR;
	assign last = cnt == 8'(mem_bus_pkg::OAM_BYTES);   // Only flushes the final write

	always_ff @(posedge gbclk or negedge arst_n) begin
		if (!arst_n) begin
			dma_active <= 1'b0;
			cnt <= '0;
			oam_index <= '0;
		end else begin
			oam_index <= cnt;   // Write side trails the read by one cycle
			if (start) begin
				dma_active <= 1'b1;
				cnt <= '0;
			end else if (dma_active) begin
				if (last) begin
					dma_active <= 1'b0;
				end else begin
					cnt <= cnt + 8'd1;
				end
			end
		end
	end

	always_ff @(posedge gbclk) begin
		if (start) begin
			page <= cpu.wdata;
		end
	end

	// The engine only ever reads its source
	assign dma.addr = {page, cnt};
	assign dma.rd = dma_active;
	assign dma.wr = 1'b0;
	assign dma.wdata = '0;

endmodule

`default_nettype wire

// ==== source/bus_steer.sv ====
`default_nettype none

module bus_steer (
	input logic gbclk,
	input logic arst_n,
	bus_req_if.steer req [mem_bus_pkg::NUM_MASTERS],
	input logic ppu_need_vram,
	input logic ppu_need_oam,
	input logic dma_active,
	input logic [7:0] oam_index,
	input mem_bus_pkg::data_t dma_rdata,
	output logic [12:0] vram_addr,
	output logic vram_rd,
	output logic vram_wr,
	output logic [7:0] oam_addr,
	output logic oam_rd,
	output logic oam_wr,
	output mem_bus_pkg::data_t oam_wdata,
	output logic [6:0] hram_addr,
	output logic hram_rd,
	output logic hram_wr,
	output mem_bus_pkg::data_t wdata,
	output mem_bus_pkg::addr_t ext_addr,
	output logic ext_rd,
	output logic ext_wr,
	output mem_bus_pkg::data_t ext_wdata,
	output logic cs_rom,
	output logic cs_xram,
	output logic cs_wram,
	output logic cpu_granted
);

	mem_bus_pkg::region_t cpu_reg;
	mem_bus_pkg::region_t dma_reg;
	mem_bus_pkg::region_t ext_reg;
	mem_bus_pkg::addr_t cpu_addr;
	mem_bus_pkg::addr_t dma_addr;
	logic cpu_vram_ok;
	logic cpu_oam_ok;
	logic cpu_ext_ok;
	logic dma_on_vram;
	logic dma_on_ext;
	logic dma_wr_hold;

	function automatic logic is_ext(mem_bus_pkg::region_t r);
		return r == mem_bus_pkg::REG_ROM || r == mem_bus_pkg::REG_XRAM ||
			r == mem_bus_pkg::REG_WRAM;
	endfunction

	assign cpu_reg = req[mem_bus_pkg::M_CPU].region;
	assign dma_reg = req[mem_bus_pkg::M_DMA].region;
	assign cpu_addr = req[mem_bus_pkg::M_CPU].addr;
	assign dma_addr = req[mem_bus_pkg::M_DMA].addr;

	assign dma_on_vram = dma_active && dma_reg == mem_bus_pkg::REG_VRAM;
	assign dma_on_ext = dma_active && is_ext(dma_reg);   // Whole external bus is held

	assign cpu_vram_ok = cpu_reg == mem_bus_pkg::REG_VRAM && !ppu_need_vram && !dma_on_vram;
	assign cpu_oam_ok = cpu_reg == mem_bus_pkg::REG_OAM && !ppu_need_oam && !dma_active;
	assign cpu_ext_ok = is_ext(cpu_reg) && !dma_on_ext;
	assign cpu_granted = cpu_vram_ok || cpu_oam_ok || cpu_ext_ok ||
		cpu_reg == mem_bus_pkg::REG_HRAM;

	always_comb begin
		vram_addr = cpu_addr[12:0];
		vram_rd = 1'b0;
		vram_wr = 1'b0;
		if (ppu_need_vram) begin
			vram_addr = req[mem_bus_pkg::M_PPU].addr[12:0];
			vram_rd = req[mem_bus_pkg::M_PPU].region == mem_bus_pkg::REG_VRAM;
		end else if (dma_on_vram) begin
			vram_addr = dma_addr[12:0];
			vram_rd = req[mem_bus_pkg::M_DMA].rd;
		end else if (cpu_vram_ok) begin
			vram_rd = req[mem_bus_pkg::M_CPU].rd;
			vram_wr = req[mem_bus_pkg::M_CPU].wr;
		end
	end

	always_comb begin
		oam_addr = cpu_addr[7:0];
		oam_rd = 1'b0;
		oam_wr = 1'b0;
		oam_wdata = req[mem_bus_pkg::M_CPU].wdata;
		if (ppu_need_oam) begin
			oam_addr = req[mem_bus_pkg::M_PPU].addr[7:0];
			oam_rd = req[mem_bus_pkg::M_PPU].region == mem_bus_pkg::REG_OAM;
		end else if (dma_active) begin
			oam_addr = oam_index;
			oam_wr = dma_wr_hold && oam_index < 8'(mem_bus_pkg::OAM_BYTES);
			oam_wdata = dma_rdata;   // Byte fetched by the previous DMA read
		end else if (cpu_oam_ok) begin
			oam_rd = req[mem_bus_pkg::M_CPU].rd;
			oam_wr = req[mem_bus_pkg::M_CPU].wr;
		end
	end

	always_comb begin
		ext_reg = cpu_reg;
		ext_addr = cpu_addr;
		ext_rd = cpu_ext_ok && req[mem_bus_pkg::M_CPU].rd;
		ext_wr = cpu_ext_ok && req[mem_bus_pkg::M_CPU].wr;
		if (dma_on_ext) begin
			ext_reg = dma_reg;
			ext_addr = dma_addr;
			ext_rd = req[mem_bus_pkg::M_DMA].rd;
			ext_wr = 1'b0;
		end
	end

	assign cs_rom = (ext_rd || ext_wr) && ext_reg == mem_bus_pkg::REG_ROM;
	assign cs_xram = (ext_rd || ext_wr) && ext_reg == mem_bus_pkg::REG_XRAM;
	assign cs_wram = (ext_rd || ext_wr) && ext_reg == mem_bus_pkg::REG_WRAM;

	assign hram_addr = cpu_addr[6:0];
	assign hram_rd = req[mem_bus_pkg::M_CPU].rd && cpu_reg == mem_bus_pkg::REG_HRAM;
	assign hram_wr = req[mem_bus_pkg::M_CPU].wr && cpu_reg == mem_bus_pkg::REG_HRAM;
	assign wdata = req[mem_bus_pkg::M_CPU].wdata;
	assign ext_wdata = req[mem_bus_pkg::M_CPU].wdata;

	always_ff @(posedge gbclk or negedge arst_n) begin
		if (!arst_n) begin
			dma_wr_hold <= 1'b0;
		end else begin
			dma_wr_hold <= dma_active && req[mem_bus_pkg::M_DMA].rd;
		end
	end

endmodule

`default_nettype wire

// ==== source/local_mem.sv ====
`default_nettype none

module local_mem (
	input logic gbclk,
	input logic [12:0] vram_addr,
	input logic vram_rd,
	input logic vram_wr,
	input logic [7:0] oam_addr,
	input logic oam_rd,
	input logic oam_wr,
	input mem_bus_pkg::data_t oam_wdata,
	input logic [6:0] hram_addr,
	input logic hram_rd,
	input logic hram_wr,
	input mem_bus_pkg::data_t wdata,
	output mem_bus_pkg::data_t vram_rdata,
	output mem_bus_pkg::data_t oam_rdata,
	output mem_bus_pkg::data_t hram_rdata
);

	mem_bus_pkg::data_t vram_mem [mem_bus_pkg::VRAM_WORDS];
	mem_bus_pkg::data_t oam_mem [mem_bus_pkg::OAM_BYTES];
	mem_bus_pkg::data_t hram_mem [mem_bus_pkg::HRAM_BYTES];

	// Read data holds until the next read strobe
	always_ff @(posedge gbclk) begin
		if (vram_wr) begin
			vram_mem[vram_addr] <= wdata;
		end
		if (vram_rd) begin
			vram_rdata <= vram_mem[vram_addr];
		end
	end

	always_ff @(posedge gbclk) begin
		if (oam_wr) begin
			oam_mem[oam_addr] <= oam_wdata;   // Shared by CPU and DMA writes
		end
		if (oam_rd) begin
			oam_rdata <= oam_mem[oam_addr];
		end
	end

	always_ff @(posedge gbclk) begin
		if (hram_wr) begin
			hram_mem[hram_addr] <= wdata;
		end
		if (hram_rd) begin
			hram_rdata <= hram_mem[hram_addr];
		end
	end

endmodule

`default_nettype wire

// ==== source/cpu_read_mux.sv ====
`default_nettype none

module cpu_read_mux (
	input logic gbclk,
	input logic arst_n,
	input mem_bus_pkg::region_t cpu_region,
	input logic cpu_rd,
	input logic cpu_granted,
	input mem_bus_pkg::region_t dma_region,
	input logic ppu_need_oam,
	input mem_bus_pkg::data_t vram_rdata,
	input mem_bus_pkg::data_t oam_rdata,
	input mem_bus_pkg::data_t hram_rdata,
	input mem_bus_pkg::data_t ext_rdata,
	output mem_bus_pkg::data_t cpu_rdata,
	output mem_bus_pkg::data_t dma_rdata,
	output mem_bus_pkg::data_t ppu_rdata
);

	mem_bus_pkg::region_t cpu_sel;
	mem_bus_pkg::region_t dma_sel;
	logic ppu_oam_sel;

	always_ff @(posedge gbclk or negedge arst_n) begin
		if (!arst_n) begin
			cpu_sel <= mem_bus_pkg::REG_NONE;
			dma_sel <= mem_bus_pkg::REG_NONE;
			ppu_oam_sel <= 1'b0;
		end else begin
			cpu_sel <= (cpu_rd && cpu_granted) ? cpu_region : mem_bus_pkg::REG_NONE;
			dma_sel <= dma_region;   // Idle DMA decodes as none
			ppu_oam_sel <= ppu_need_oam;
		end
	end

	always_comb begin
		case (cpu_sel)
			mem_bus_pkg::REG_VRAM: cpu_rdata = vram_rdata;
			mem_bus_pkg::REG_OAM: cpu_rdata = oam_rdata;
			mem_bus_pkg::REG_HRAM: cpu_rdata = hram_rdata;
			mem_bus_pkg::REG_ROM,
			mem_bus_pkg::REG_XRAM,
			mem_bus_pkg::REG_WRAM: cpu_rdata = ext_rdata;
			default: cpu_rdata = mem_bus_pkg::OPEN_BUS;   // Dropped reads, I/O and holes
		endcase
	end

	always_comb begin
		case (dma_sel)
			mem_bus_pkg::REG_VRAM: dma_rdata = vram_rdata;
			mem_bus_pkg::REG_ROM,
			mem_bus_pkg::REG_XRAM,
			mem_bus_pkg::REG_WRAM: dma_rdata = ext_rdata;
			default: dma_rdata = mem_bus_pkg::OPEN_BUS;
		endcase
	end

	assign ppu_rdata = ppu_oam_sel ? oam_rdata : vram_rdata;

endmodule

`default_nettype wire

// ==== source/mem_bus_top.sv ====
`default_nettype none

module mem_bus_top (
	input logic gbclk,
	input logic arst_n,
	input mem_bus_pkg::addr_t cpu_addr,
	input logic cpu_rd,
	input logic cpu_wr,
	input mem_bus_pkg::data_t cpu_wdata,
	output mem_bus_pkg::data_t cpu_rdata,
	input mem_bus_pkg::addr_t ppu_addr,
	input logic ppu_rd,
	input logic ppu_need_vram,
	input logic ppu_need_oam,
	output mem_bus_pkg::data_t ppu_rdata,
	output mem_bus_pkg::addr_t ext_addr,
	output logic ext_rd,
	output logic ext_wr,
	output mem_bus_pkg::data_t ext_wdata,
	output logic cs_rom,
	output logic cs_xram,
	output logic cs_wram,
	input mem_bus_pkg::data_t ext_rdata,
	output logic dma_active
);

	bus_req_if req [mem_bus_pkg::NUM_MASTERS] ();

	logic [7:0] oam_index;
	logic cpu_granted;
	logic [12:0] vram_addr;
	logic vram_rd;
	logic vram_wr;
	logic [7:0] oam_addr;
	logic oam_rd;
	logic oam_wr;
	mem_bus_pkg::data_t oam_wdata;
	logic [6:0] hram_addr;
	logic hram_rd;
	logic hram_wr;
	mem_bus_pkg::data_t wdata;
	mem_bus_pkg::data_t vram_rdata;
	mem_bus_pkg::data_t oam_rdata;
	mem_bus_pkg::data_t hram_rdata;
	mem_bus_pkg::data_t dma_rdata;

	assign req[mem_bus_pkg::M_CPU].addr = cpu_addr;
	assign req[mem_bus_pkg::M_CPU].rd = cpu_rd;
	assign req[mem_bus_pkg::M_CPU].wr = cpu_wr;
	assign req[mem_bus_pkg::M_CPU].wdata = cpu_wdata;

	// The PPU never writes through this bus
	assign req[mem_bus_pkg::M_PPU].addr = ppu_addr;
	assign req[mem_bus_pkg::M_PPU].rd = ppu_rd;
	assign req[mem_bus_pkg::M_PPU].wr = 1'b0;
	assign req[mem_bus_pkg::M_PPU].wdata = '0;

	for (genvar i = 0; i < mem_bus_pkg::NUM_MASTERS; i++) begin : g_dec
		region_decoder u_dec (
			.req(req[i])
		);
	end

	oam_dma u_dma (
		.cpu(req[mem_bus_pkg::M_CPU]),
		.dma(req[mem_bus_pkg::M_DMA]),
		.*
	);

	bus_steer u_steer (
		.req(req),
		.*
	);

	local_mem u_mem (
		.*
	);

	cpu_read_mux u_rmux (
		.cpu_region(req[mem_bus_pkg::M_CPU].region),
		.dma_region(req[mem_bus_pkg::M_DMA].region),
		.*
	);

endmodule

`default_nettype wire

// ==== dv/mem_bus_sva.sv ====
`default_nettype none

module mem_bus_sva (
	input logic gbclk,
	input logic arst_n,
	input logic ppu_need_vram,
	input logic vram_wr,
	input logic cpu_granted,
	input mem_bus_pkg::region_t cpu_reg,
	input logic cs_rom,
	input logic cs_xram,
	input logic cs_wram,
	input mem_bus_pkg::addr_t ext_addr,
	input logic ext_wr,
	input logic dma_active,
	input mem_bus_pkg::region_t dma_reg,
	input mem_bus_pkg::addr_t dma_addr
);

	int fail_count = 0;

	ppu_owns_vram: assert property (@(posedge gbclk) disable iff (!arst_n)
		ppu_need_vram |-> !vram_wr && !(cpu_granted && cpu_reg == mem_bus_pkg::REG_VRAM))
	else begin
		fail_count++;
		$error("CPU or DMA strobed VRAM while the PPU held it");
	end

	// The external device sees one chip at a time, each only inside its own range
	one_chip_select: assert property (@(posedge gbclk) disable iff (!arst_n)
		$onehot0({cs_rom, cs_xram, cs_wram}) &&
		(!cs_rom || ext_addr <= mem_bus_pkg::ROM_LIMIT) &&
		(!cs_xram || (ext_addr >= mem_bus_pkg::XRAM_BASE &&
			ext_addr <= mem_bus_pkg::XRAM_LIMIT)) &&
		(!cs_wram || (ext_addr >= mem_bus_pkg::WRAM_BASE &&
			ext_addr <= mem_bus_pkg::ECHO_LIMIT)))
	else begin
		fail_count++;
		$error("Chip selects do not match the external address");
	end

	no_write_during_dma: assert property (@(posedge gbclk) disable iff (!arst_n)
		(dma_active && dma_reg inside {mem_bus_pkg::REG_ROM, mem_bus_pkg::REG_XRAM,
			mem_bus_pkg::REG_WRAM}) |-> !ext_wr && ext_addr == dma_addr)
	else begin
		fail_count++;
		$error("External write or foreign address while the DMA reads an external source");
	end

endmodule

bind bus_steer mem_bus_sva u_sva (
	.gbclk(gbclk),
	.arst_n(arst_n),
	.ppu_need_vram(ppu_need_vram),
	.vram_wr(vram_wr),
	.cpu_granted(cpu_granted),
	.cpu_reg(cpu_reg),
	.cs_rom(cs_rom),
	.cs_xram(cs_xram),
	.cs_wram(cs_wram),
	.ext_addr(ext_addr),
	.ext_wr(ext_wr),
	.dma_active(dma_active),
	.dma_reg(dma_reg),
	.dma_addr(dma_addr)
);

`default_nettype wire

// ==== dv/mem_bus_tb.sv ====
`default_nettype none

module mem_bus_tb;

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_PPU_ON, OP_PPU_OFF} op_t;

	typedef struct {
		op_t op;
		mem_bus_pkg::addr_t addr;
		mem_bus_pkg::data_t data;
		mem_bus_pkg::data_t exp;
		mem_bus_pkg::region_t sel;
	} step_t;

	logic gbclk;
	logic arst_n;
	mem_bus_pkg::addr_t cpu_addr;
	logic cpu_rd;
	logic cpu_wr;
	mem_bus_pkg::data_t cpu_wdata;
	mem_bus_pkg::data_t cpu_rdata;
	mem_bus_pkg::addr_t ppu_addr;
	logic ppu_rd;
	logic ppu_need_vram;
	logic ppu_need_oam;
	mem_bus_pkg::data_t ppu_rdata;
	mem_bus_pkg::addr_t ext_addr;
	logic ext_rd;
	logic ext_wr;
	mem_bus_pkg::data_t ext_wdata;
	logic cs_rom;
	logic cs_xram;
	logic cs_wram;
	mem_bus_pkg::data_t ext_rdata;
	logic dma_active;

	mem_bus_pkg::data_t ext_mem [65536];
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int sva_fails;

	step_t steps [26] = '{
		'{OP_WR, 16'h8123, 8'h5a, 8'h00, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'h8123, 8'h00, 8'h5a, mem_bus_pkg::REG_NONE},
		'{OP_WR, 16'hfe10, 8'ha5, 8'h00, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'hfe10, 8'h00, 8'ha5, mem_bus_pkg::REG_NONE},
		'{OP_WR, 16'hff90, 8'h3c, 8'h00, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'hff90, 8'h00, 8'h3c, mem_bus_pkg::REG_NONE},
		'{OP_WR, 16'hfffe, 8'h77, 8'h00, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'hfffe, 8'h00, 8'h77, mem_bus_pkg::REG_NONE},
		'{OP_WR, 16'h1234, 8'h11, 8'h00, mem_bus_pkg::REG_ROM},
		'{OP_RD, 16'h1234, 8'h00, 8'h11, mem_bus_pkg::REG_ROM},
		'{OP_WR, 16'ha010, 8'h22, 8'h00, mem_bus_pkg::REG_XRAM},
		'{OP_RD, 16'ha010, 8'h00, 8'h22, mem_bus_pkg::REG_XRAM},
		'{OP_WR, 16'hc020, 8'h33, 8'h00, mem_bus_pkg::REG_WRAM},
		'{OP_RD, 16'hc020, 8'h00, 8'h33, mem_bus_pkg::REG_WRAM},
		'{OP_WR, 16'he040, 8'h44, 8'h00, mem_bus_pkg::REG_WRAM},   // Echo of work RAM
		'{OP_RD, 16'he040, 8'h00, 8'h44, mem_bus_pkg::REG_WRAM},
		'{OP_RD, 16'hff00, 8'h00, 8'hff, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'hff10, 8'h00, 8'hff, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'hffff, 8'h00, 8'hff, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'hfea0, 8'h00, 8'hff, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'hfeff, 8'h00, 8'hff, mem_bus_pkg::REG_NONE},
		'{OP_PPU_ON, 16'h8123, 8'h00, 8'h00, mem_bus_pkg::REG_NONE},
		'{OP_WR, 16'h8123, 8'h99, 8'h00, mem_bus_pkg::REG_NONE},
		'{OP_RD, 16'h8123, 8'h00, 8'hff, mem_bus_pkg::REG_NONE},
		'{OP_PPU_OFF, 16'h8123, 8'h00, 8'h5a, mem_bus_pkg::REG_NONE},   // PPU still sees the old byte
		'{OP_RD, 16'h8123, 8'h00, 8'h5a, mem_bus_pkg::REG_NONE}   // Old byte survives
	};

	mem_bus_top dut0 (
		.*
	);

	initial begin
		gbclk = 1'b0;
		forever #50 gbclk = ~gbclk;
	end

	// External memory answers one cycle after the read strobe
	initial begin
		ext_rdata = '0;
		for (int a = 0; a < 65536; a++) begin
			ext_mem[a] = 8'(a[15:8] ^ a[7:0] ^ 8'h5c);
		end
	end

	always @(posedge gbclk) begin
		if (ext_wr) begin
			ext_mem[ext_addr] <= ext_wdata;
		end
		if (ext_rd) begin
			ext_rdata <= ext_mem[ext_addr];
		end
	end

	task automatic check_data(input string name, input mem_bus_pkg::data_t got,
		input mem_bus_pkg::data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_sel(input string name, input mem_bus_pkg::region_t got,
		input mem_bus_pkg::region_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at time %0t: %s is %s, expected %s", $time, name, got.name(),
				exp.name());
		end
	endtask

	function automatic mem_bus_pkg::region_t raised_select();
		if (cs_rom) begin
			return mem_bus_pkg::REG_ROM;
		end else if (cs_xram) begin
			return mem_bus_pkg::REG_XRAM;
		end else if (cs_wram) begin
			return mem_bus_pkg::REG_WRAM;
		end
		return mem_bus_pkg::REG_NONE;
	endfunction

	// One strobe cycle, then the read byte one cycle later
	task automatic access(input logic write, input mem_bus_pkg::addr_t a,
		input mem_bus_pkg::data_t d, output mem_bus_pkg::region_t sel,
		output mem_bus_pkg::data_t rdata);
		@(posedge gbclk);
		cpu_addr <= a;
		cpu_rd <= !write;
		cpu_wr <= write;
		cpu_wdata <= d;
		@(negedge gbclk);
		sel = raised_select();
		@(posedge gbclk);
		cpu_rd <= 1'b0;
		cpu_wr <= 1'b0;
		@(negedge gbclk);
		rdata = cpu_rdata;
	endtask

	task automatic wait_dma(input logic level, input int limit, output bit ok);
		int n;
		n = 0;
		while (dma_active !== level && n < limit) begin
			@(negedge gbclk);
			n++;
		end
		ok = dma_active === level;
		if (!ok) begin
			timeouts++;
			$display("dma_active did not become %0b within %0d cycles", level, limit);
		end
	endtask

	task automatic apply_step(input step_t s);
		mem_bus_pkg::region_t sel;
		mem_bus_pkg::data_t rd;
		case (s.op)
			OP_WR: begin
				access(1'b1, s.addr, s.data, sel, rd);
				check_sel("chip select", sel, s.sel);
				if (s.sel != mem_bus_pkg::REG_NONE) begin
					check_data("ext_mem", ext_mem[s.addr], s.data);
				end
			end
			OP_RD: begin
				access(1'b0, s.addr, s.data, sel, rd);
				check_sel("chip select", sel, s.sel);
				check_data("cpu_rdata", rd, s.exp);
			end
			OP_PPU_ON: begin
				@(posedge gbclk);
				ppu_addr <= s.addr;
				ppu_rd <= 1'b1;
				ppu_need_vram <= 1'b1;
			end
			default: begin
				check_data("ppu_rdata", ppu_rdata, s.exp);
				@(posedge gbclk);
				ppu_rd <= 1'b0;
				ppu_need_vram <= 1'b0;
			end
		endcase
	endtask

	task automatic run_dma(output bit ok);
		mem_bus_pkg::data_t page_bytes [mem_bus_pkg::OAM_BYTES];
		mem_bus_pkg::region_t sel;
		mem_bus_pkg::data_t rd;
		for (int i = 0; i < mem_bus_pkg::OAM_BYTES; i++) begin
			page_bytes[i] = 8'($urandom);
			ext_mem[{8'hc1, 8'(i)}] = page_bytes[i];
		end
		access(1'b1, mem_bus_pkg::DMA_REG_ADDR, 8'hc1, sel, rd);
		check_sel("chip select", sel, mem_bus_pkg::REG_NONE);
		wait_dma(1'b1, 10, ok);
		if (!ok) begin
			return;
		end
		access(1'b0, mem_bus_pkg::OAM_BASE, 8'h00, sel, rd);
		check_data("cpu_rdata", rd, mem_bus_pkg::OPEN_BUS);
		access(1'b1, mem_bus_pkg::OAM_BASE, ~page_bytes[0], sel, rd);   // Byte 0 is copied by now
		wait_dma(1'b0, 400, ok);
		if (!ok) begin
			return;
		end
		for (int i = 0; i < mem_bus_pkg::OAM_BYTES; i++) begin
			access(1'b0, 16'(mem_bus_pkg::OAM_BASE + i), 8'h00, sel, rd);
			check_data("cpu_rdata", rd, page_bytes[i]);
		end
	endtask

	initial begin
		bit ok;
		void'($urandom(32'h1aa2_d3d5));
		arst_n = 1'b0;
		cpu_addr = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_wdata = '0;
		ppu_addr = '0;
		ppu_rd = 1'b0;
		ppu_need_vram = 1'b0;
		ppu_need_oam = 1'b0;
		repeat (5) @(posedge gbclk);
		arst_n <= 1'b1;
		for (int i = 0; i < $size(steps); i++) begin
			apply_step(steps[i]);
		end
		run_dma(ok);
		sva_fails = dut0.u_steer.u_sva.fail_count;
		$display("Checks %0d, errors %0d, assertion failures %0d, timeouts %0d", checks,
			errors, sva_fails, timeouts);
		if (errors == 0 && sva_fails == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/mem_bus_pkg.sv
source/bus_req_if.sv
source/region_decoder.sv
source/oam_dma.sv
source/bus_steer.sv
source/local_mem.sv
source/cpu_read_mux.sv
source/mem_bus_top.sv
dv/mem_bus_sva.sv
dv/mem_bus_tb.sv
